//--- cpu_config.svh
/* CPU build parameters */

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and instruction width
`define CPU_WORD_W 16

// Register file size
`define CPU_REG_COUNT 8

// Shared memory size in words
`define CPU_MEM_DEPTH 256

// First instruction after start
`define CPU_START_PC 0

`endif

//--- cpu_pkg.sv
/* CPU shared types */

`include "cpu_config.svh"

package cpu_pkg;

   // One data or instruction word
   typedef logic [`CPU_WORD_W-1:0] word_t;

   typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

   // Word address, low bits of a computed address
   typedef logic [$clog2(`CPU_MEM_DEPTH)-1:0] mem_addr_t;

   // Opcode field, bits 15 to 12
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_HALT = 4'd1,
      OP_ADD  = 4'd2,
      OP_SUB  = 4'd3,
      OP_AND  = 4'd4,
      OP_XOR  = 4'd5,
      OP_ADDI = 4'd6,
      OP_LD   = 4'd7,
      OP_ST   = 4'd8
   } opcode_t;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR
   } alu_op_t;

   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_RUN,
      FETCH_DRAIN
   } fetch_state_t;

endpackage

//--- mem_arbiter.sv
/* Shared memory and port arbiter */

`timescale 1ns/1ps

`include "cpu_config.svh"

module mem_arbiter (
   input  logic               clk,
   input  logic               rst,
   input  logic               busy,
   input  logic               prog_we,
   input  cpu_pkg::mem_addr_t prog_addr,
   input  cpu_pkg::word_t     prog_data,
   input  logic               data_req,
   input  logic               data_we,
   input  cpu_pkg::mem_addr_t data_addr,
   input  cpu_pkg::word_t     data_wdata,
   input  logic               fetch_req,
   input  cpu_pkg::mem_addr_t fetch_addr,
   output logic               fetch_grant,
   output cpu_pkg::word_t     rdata
);
   import cpu_pkg::*;

   word_t     mem [`CPU_MEM_DEPTH];
   logic      load_sel;
   logic      data_wr;
   mem_addr_t rd_addr;

   // Loader owns the port only while the CPU is idle
   assign load_sel = prog_we && !busy;

   // Data stage is never refused
   assign data_wr = data_req && data_we && !load_sel;

   // Fetch takes whatever cycle is left
   assign fetch_grant = fetch_req && !data_req && !load_sel;

   // Single read port, data access wins the address
   assign rd_addr = data_req ? data_addr : fetch_addr;
   assign rdata   = mem[rd_addr];

   // Writes land at the edge, none while reset is held
   always_ff @(posedge clk) begin
      if (!rst) begin
         if (load_sel) begin
            mem[prog_addr] <= prog_data;
         end else if (data_wr) begin
            mem[data_addr] <= data_wdata;
         end
      end
   end

endmodule

//--- fetch_stage.sv
/* Fetch stage and IF/ID register */

`timescale 1ns/1ps

`include "cpu_config.svh"

module fetch_stage (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  logic               stall,
   input  logic               halt_seen,
   input  logic               halt_retired,
   input  logic               fetch_grant,
   input  cpu_pkg::word_t     rdata,
   output logic               busy,
   output logic               fetch_req,
   output cpu_pkg::mem_addr_t fetch_addr,
   output cpu_pkg::word_t     instr_ifid,
   output logic               valid_ifid
);
   import cpu_pkg::*;

   fetch_state_t state;
   mem_addr_t    pc;

   assign busy       = (state != FETCH_IDLE);
   assign fetch_addr = pc;

   // No request while IF/ID is frozen or a HALT sits in decode
   assign fetch_req = (state == FETCH_RUN) && !stall && !halt_seen;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= FETCH_IDLE;
      end else begin
         case (state)
            FETCH_IDLE: begin
               if (start) begin
                  state <= FETCH_RUN;
               end
            end
            FETCH_RUN: begin
               if (halt_seen) begin
                  state <= FETCH_DRAIN;
               end
            end
            default: begin
               // Wait for the HALT to leave MEM/WB
               if (halt_retired) begin
                  state <= FETCH_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst || (state == FETCH_IDLE && start)) begin
         pc <= mem_addr_t'(`CPU_START_PC);
      end else if (fetch_grant) begin
         pc <= pc + mem_addr_t'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_ifid <= 1'b0;
      end else if (!stall) begin
         valid_ifid <= fetch_grant;
      end
   end

   // Denied fetch leaves a NOP bubble
   always_ff @(posedge clk) begin
      if (!stall) begin
         instr_ifid <= fetch_grant ? rdata : word_t'({OP_NOP, 12'd0});
      end
   end

endmodule

//--- decode_stage.sv
/* Decode stage and ID/EX register */

`timescale 1ns/1ps

`include "cpu_config.svh"

module decode_stage (
   input  logic              clk,
   input  logic              rst,
   input  cpu_pkg::word_t    instr_ifid,
   input  logic              valid_ifid,
   input  logic              wb_en,
   input  cpu_pkg::reg_idx_t wb_reg,
   input  cpu_pkg::word_t    wb_data,
   output logic              stall,
   output logic              halt_seen,
   output logic              err,
   output cpu_pkg::alu_op_t  alu_op_idex,
   output cpu_pkg::word_t    opa_idex,
   output cpu_pkg::word_t    opb_idex,
   output cpu_pkg::word_t    imm_idex,
   output cpu_pkg::reg_idx_t rs_idex,
   output cpu_pkg::reg_idx_t rt_idex,
   output cpu_pkg::reg_idx_t rd_idex,
   output logic              use_imm_idex,
   output logic              mem_rd_idex,
   output logic              mem_wr_idex,
   output logic              reg_wr_idex,
   output logic              halt_idex
);
   import cpu_pkg::*;

   opcode_t  opcode;
   reg_idx_t rd;
   reg_idx_t rs;
   reg_idx_t src_b;
   word_t    imm;
   word_t    rf [`CPU_REG_COUNT];
   word_t    rs_val;
   word_t    src_b_val;
   alu_op_t  alu_op;
   logic     use_imm;
   logic     uses_rs;
   logic     uses_b;
   logic     mem_rd;
   logic     mem_wr;
   logic     reg_wr;
   logic     illegal;
   logic     issue;

   assign opcode = opcode_t'(instr_ifid[15:12]);
   assign rd     = instr_ifid[11:9];
   assign rs     = instr_ifid[8:6];
   assign imm    = {{(`CPU_WORD_W-6){instr_ifid[5]}}, instr_ifid[5:0]};

   // ST reads rd as its store data
   assign src_b = (opcode == OP_ST) ? rd : instr_ifid[5:3];

   always_comb begin
      alu_op  = ALU_ADD;
      use_imm = 1'b0;
      uses_rs = 1'b0;
      uses_b  = 1'b0;
      mem_rd  = 1'b0;
      mem_wr  = 1'b0;
      reg_wr  = 1'b0;
      illegal = 1'b0;
      case (opcode)
         OP_NOP, OP_HALT: begin
         end
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            uses_rs = 1'b1;
            uses_b  = 1'b1;
            reg_wr  = 1'b1;
            if (opcode == OP_SUB) begin
               alu_op = ALU_SUB;
            end else if (opcode == OP_AND) begin
               alu_op = ALU_AND;
            end else if (opcode == OP_XOR) begin
               alu_op = ALU_XOR;
            end
         end
         OP_ADDI, OP_LD: begin
            uses_rs = 1'b1;
            use_imm = 1'b1;
            reg_wr  = 1'b1;
            mem_rd  = (opcode == OP_LD);
         end
         OP_ST: begin
            uses_rs = 1'b1;
            uses_b  = 1'b1;
            use_imm = 1'b1;
            mem_wr  = 1'b1;
         end
         default: illegal = 1'b1;
      endcase
   end

   // Write-through read, the retiring value is seen this cycle
   assign rs_val    = (wb_en && wb_reg == rs) ? wb_data : rf[rs];
   assign src_b_val = (wb_en && wb_reg == src_b) ? wb_data : rf[src_b];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_en) begin
         rf[wb_reg] <= wb_data;
      end
   end

   // Load in EX has no data to forward yet
   assign stall = valid_ifid && mem_rd_idex &&
                  ((uses_rs && rs == rd_idex) || (uses_b && src_b == rd_idex));

   assign halt_seen = valid_ifid && (opcode == OP_HALT);
   assign issue     = valid_ifid && !stall;

   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else if (valid_ifid && illegal) begin
         err <= 1'b1;
      end
   end

   // Bubble and illegal opcode leave all control bits low
   always_ff @(posedge clk) begin
      if (rst) begin
         reg_wr_idex <= 1'b0;
         mem_rd_idex <= 1'b0;
         mem_wr_idex <= 1'b0;
         halt_idex   <= 1'b0;
      end else begin
         reg_wr_idex <= issue && reg_wr;
         mem_rd_idex <= issue && mem_rd;
         mem_wr_idex <= issue && mem_wr;
         halt_idex   <= halt_seen;
      end
   end

   always_ff @(posedge clk) begin
      alu_op_idex  <= alu_op;
      opa_idex     <= rs_val;
      opb_idex     <= src_b_val;
      imm_idex     <= imm;
      rs_idex      <= rs;
      rt_idex      <= src_b;
      rd_idex      <= rd;
      use_imm_idex <= use_imm;
   end

endmodule

//--- execute_stage.sv
/* Execute stage and EX/MEM register */

`timescale 1ns/1ps

module execute_stage (
   input  logic              clk,
   input  logic              rst,
   input  cpu_pkg::alu_op_t  alu_op_idex,
   input  cpu_pkg::word_t    opa_idex,
   input  cpu_pkg::word_t    opb_idex,
   input  cpu_pkg::word_t    imm_idex,
   input  cpu_pkg::reg_idx_t rs_idex,
   input  cpu_pkg::reg_idx_t rt_idex,
   input  cpu_pkg::reg_idx_t rd_idex,
   input  logic              use_imm_idex,
   input  logic              mem_rd_idex,
   input  logic              mem_wr_idex,
   input  logic              reg_wr_idex,
   input  logic              halt_idex,
   input  cpu_pkg::word_t    wb_data,
   input  cpu_pkg::reg_idx_t wb_reg,
   input  logic              wb_en,
   output cpu_pkg::word_t    alu_exmem,
   output cpu_pkg::word_t    store_exmem,
   output cpu_pkg::reg_idx_t rd_exmem,
   output logic              reg_wr_exmem,
   output logic              mem_rd_exmem,
   output logic              mem_wr_exmem,
   output logic              halt_exmem
);
   import cpu_pkg::*;

   word_t opa;
   word_t opb;
   word_t alu_b;
   word_t alu_y;
   logic  ex_src;

   // A load in EX/MEM is not a source, decode stalls that case
   assign ex_src = reg_wr_exmem && !mem_rd_exmem;

   // EX/MEM first, then MEM/WB
   always_comb begin
      if (ex_src && rd_exmem == rs_idex) begin
         opa = alu_exmem;
      end else if (wb_en && wb_reg == rs_idex) begin
         opa = wb_data;
      end else begin
         opa = opa_idex;
      end
   end

   always_comb begin
      if (ex_src && rd_exmem == rt_idex) begin
         opb = alu_exmem;
      end else if (wb_en && wb_reg == rt_idex) begin
         opb = wb_data;
      end else begin
         opb = opb_idex;
      end
   end

   assign alu_b = use_imm_idex ? imm_idex : opb;

   // Also the address for LD and ST
   always_comb begin
      case (alu_op_idex)
         ALU_ADD: alu_y = opa + alu_b;
         ALU_SUB: alu_y = opa - alu_b;
         ALU_AND: alu_y = opa & alu_b;
         default: alu_y = opa ^ alu_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         reg_wr_exmem <= 1'b0;
         mem_rd_exmem <= 1'b0;
         mem_wr_exmem <= 1'b0;
         halt_exmem   <= 1'b0;
      end else begin
         reg_wr_exmem <= reg_wr_idex;
         mem_rd_exmem <= mem_rd_idex;
         mem_wr_exmem <= mem_wr_idex;
         halt_exmem   <= halt_idex;
      end
   end

   always_ff @(posedge clk) begin
      alu_exmem   <= alu_y;
      store_exmem <= opb;
      rd_exmem    <= rd_idex;
   end

endmodule

//--- mem_wb_stage.sv
/* Data access and MEM/WB register */

`timescale 1ns/1ps

module mem_wb_stage (
   input  logic               clk,
   input  logic               rst,
   input  cpu_pkg::word_t     alu_exmem,
   input  cpu_pkg::word_t     store_exmem,
   input  cpu_pkg::reg_idx_t  rd_exmem,
   input  logic               reg_wr_exmem,
   input  logic               mem_rd_exmem,
   input  logic               mem_wr_exmem,
   input  logic               halt_exmem,
   input  cpu_pkg::word_t     rdata,
   output logic               data_req,
   output logic               data_we,
   output cpu_pkg::mem_addr_t data_addr,
   output cpu_pkg::word_t     data_wdata,
   output logic               wb_en,
   output cpu_pkg::reg_idx_t  wb_reg,
   output cpu_pkg::word_t     wb_data,
   output logic               halt_retired
);
   import cpu_pkg::*;

   word_t wb_next;

   assign data_req   = mem_rd_exmem || mem_wr_exmem;
   assign data_we    = mem_wr_exmem;
   // Upper address bits wrap around
   assign data_addr  = alu_exmem[$bits(mem_addr_t)-1:0];
   assign data_wdata = store_exmem;

   // Read data arrives in the same cycle
   assign wb_next = mem_rd_exmem ? rdata : alu_exmem;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_en        <= 1'b0;
         halt_retired <= 1'b0;
      end else begin
         wb_en        <= reg_wr_exmem;
         halt_retired <= halt_exmem;
      end
   end

   always_ff @(posedge clk) begin
      wb_reg  <= rd_exmem;
      wb_data <= wb_next;
   end

endmodule

//--- cpu_top.sv
/* Five-stage pipelined 16-bit CPU */

`timescale 1ns/1ps

module cpu_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  logic               prog_we,
   input  cpu_pkg::mem_addr_t prog_addr,
   input  cpu_pkg::word_t     prog_data,
   output logic               busy,
   output logic               err,
   output logic               wb_en,
   output cpu_pkg::reg_idx_t  wb_reg,
   output cpu_pkg::word_t     wb_data
);
   import cpu_pkg::*;

   // Shared memory port
   logic      fetch_req;
   logic      fetch_grant;
   mem_addr_t fetch_addr;
   word_t     rdata;
   logic      data_req;
   logic      data_we;
   mem_addr_t data_addr;
   word_t     data_wdata;

   // IF/ID and decode status
   word_t     instr_ifid;
   logic      valid_ifid;
   logic      stall;
   logic      halt_seen;

   // ID/EX
   alu_op_t   alu_op_idex;
   word_t     opa_idex;
   word_t     opb_idex;
   word_t     imm_idex;
   reg_idx_t  rs_idex;
   reg_idx_t  rt_idex;
   reg_idx_t  rd_idex;
   logic      use_imm_idex;
   logic      mem_rd_idex;
   logic      mem_wr_idex;
   logic      reg_wr_idex;
   logic      halt_idex;

   // EX/MEM
   word_t     alu_exmem;
   word_t     store_exmem;
   reg_idx_t  rd_exmem;
   logic      reg_wr_exmem;
   logic      mem_rd_exmem;
   logic      mem_wr_exmem;
   logic      halt_exmem;
   logic      halt_retired;

   mem_arbiter u_arb (
      .clk(clk), .rst(rst), .busy(busy),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
      .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
      .data_wdata(data_wdata), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
      .fetch_grant(fetch_grant), .rdata(rdata)
   );

   fetch_stage u_fetch (
      .clk(clk), .rst(rst), .start(start), .stall(stall),
      .halt_seen(halt_seen), .halt_retired(halt_retired),
      .fetch_grant(fetch_grant), .rdata(rdata), .busy(busy),
      .fetch_req(fetch_req), .fetch_addr(fetch_addr),
      .instr_ifid(instr_ifid), .valid_ifid(valid_ifid)
   );

   decode_stage u_decode (
      .clk(clk), .rst(rst), .instr_ifid(instr_ifid), .valid_ifid(valid_ifid),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .stall(stall), .halt_seen(halt_seen), .err(err),
      .alu_op_idex(alu_op_idex), .opa_idex(opa_idex), .opb_idex(opb_idex),
      .imm_idex(imm_idex), .rs_idex(rs_idex), .rt_idex(rt_idex), .rd_idex(rd_idex),
      .use_imm_idex(use_imm_idex), .mem_rd_idex(mem_rd_idex),
      .mem_wr_idex(mem_wr_idex), .reg_wr_idex(reg_wr_idex), .halt_idex(halt_idex)
   );

   execute_stage u_execute (
      .clk(clk), .rst(rst),
      .alu_op_idex(alu_op_idex), .opa_idex(opa_idex), .opb_idex(opb_idex),
      .imm_idex(imm_idex), .rs_idex(rs_idex), .rt_idex(rt_idex), .rd_idex(rd_idex),
      .use_imm_idex(use_imm_idex), .mem_rd_idex(mem_rd_idex),
      .mem_wr_idex(mem_wr_idex), .reg_wr_idex(reg_wr_idex), .halt_idex(halt_idex),
      .wb_data(wb_data), .wb_reg(wb_reg), .wb_en(wb_en),
      .alu_exmem(alu_exmem), .store_exmem(store_exmem), .rd_exmem(rd_exmem),
      .reg_wr_exmem(reg_wr_exmem), .mem_rd_exmem(mem_rd_exmem),
      .mem_wr_exmem(mem_wr_exmem), .halt_exmem(halt_exmem)
   );

   mem_wb_stage u_mem_wb (
      .clk(clk), .rst(rst),
      .alu_exmem(alu_exmem), .store_exmem(store_exmem), .rd_exmem(rd_exmem),
      .reg_wr_exmem(reg_wr_exmem), .mem_rd_exmem(mem_rd_exmem),
      .mem_wr_exmem(mem_wr_exmem), .halt_exmem(halt_exmem), .rdata(rdata),
      .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
      .data_wdata(data_wdata), .wb_en(wb_en), .wb_reg(wb_reg),
      .wb_data(wb_data), .halt_retired(halt_retired)
   );

endmodule

//--- tb_cpu_top.sv
/* CPU directed testbench */

`timescale 1ns/1ps

`include "cpu_config.svh"

module tb_cpu_top;
   import cpu_pkg::*;

   localparam int TIMEOUT   = 400;
   localparam int POKE_ADDR = 100;

   logic        clk;
   logic        rst;
   logic        start;
   logic        prog_we;
   mem_addr_t   prog_addr;
   word_t       prog_data;
   logic        busy;
   logic        err;
   logic        wb_en;
   reg_idx_t    wb_reg;
   word_t       wb_data;

   int          value_errors;
   int          other_errors;

   // Reference model state mirroring the DUT memory
   word_t       model_mem [`CPU_MEM_DEPTH];
   word_t       model_rf [`CPU_REG_COUNT];
   logic        exp_err;
   reg_idx_t    exp_reg [$];
   word_t       exp_data [$];
   reg_idx_t    got_reg [$];
   word_t       got_data [$];
   word_t       prog [$];

   cpu_top dut0 (
      .clk(clk), .rst(rst), .start(start), .prog_we(prog_we),
      .prog_addr(prog_addr), .prog_data(prog_data), .busy(busy), .err(err),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic word_t enc_alu(opcode_t op, int rd, int rs, int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   // Immediate field takes the low 6 bits in two's complement
   function automatic word_t enc_imm(opcode_t op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERROR t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERROR t=%0t %s got r%0d expected r%0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      other_errors++;
      $display("FAILURE t=%0t %s", $time, msg);
   endtask

   // Inputs change shortly after the rising edge
   task automatic step();
      @(posedge clk);
      #5;
   endtask

   task automatic reset_dut();
      step();
      rst = 1'b1;
      start = 1'b0;
      prog_we = 1'b0;
      repeat (2) step();
      rst = 1'b0;
   endtask

   task automatic load_word(input mem_addr_t addr, input word_t data);
      prog_we = 1'b1;
      prog_addr = addr;
      prog_data = data;
      step();
      prog_we = 1'b0;
      model_mem[addr] = data;
   endtask

   task automatic load_program();
      foreach (prog[i]) begin
         load_word(mem_addr_t'(i), prog[i]);
      end
   endtask

   // Runs the program by the ISA rules until HALT
   task automatic run_model();
      word_t     instr;
      word_t     imm;
      word_t     res;
      word_t     ea;
      reg_idx_t  rd;
      reg_idx_t  rs;
      reg_idx_t  rt;
      mem_addr_t pc;
      logic      wr;
      logic      done;
      int        steps;
      exp_reg.delete();
      exp_data.delete();
      exp_err = 1'b0;
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
         model_rf[i] = '0;
      end
      pc = mem_addr_t'(`CPU_START_PC);
      done = 1'b0;
      steps = 0;
      while (!done && steps < TIMEOUT) begin
         instr = model_mem[pc];
         pc = pc + mem_addr_t'(1);
         steps++;
         rd = instr[11:9];
         rs = instr[8:6];
         rt = instr[5:3];
         imm = {{10{instr[5]}}, instr[5:0]};
         ea = model_rf[rs] + imm;
         wr = 1'b1;
         res = '0;
         case (opcode_t'(instr[15:12]))
            OP_NOP:  wr = 1'b0;
            OP_HALT: begin
               wr = 1'b0;
               done = 1'b1;
            end
            OP_ADD:  res = model_rf[rs] + model_rf[rt];
            OP_SUB:  res = model_rf[rs] - model_rf[rt];
            OP_AND:  res = model_rf[rs] & model_rf[rt];
            OP_XOR:  res = model_rf[rs] ^ model_rf[rt];
            OP_ADDI: res = ea;
            OP_LD:   res = model_mem[ea[$bits(mem_addr_t)-1:0]];
            OP_ST: begin
               wr = 1'b0;
               model_mem[ea[$bits(mem_addr_t)-1:0]] = model_rf[rd];
            end
            default: begin
               wr = 1'b0;
               exp_err = 1'b1;
            end
         endcase
         if (wr) begin
            model_rf[rd] = res;
            exp_reg.push_back(rd);
            exp_data.push_back(res);
         end
      end
      if (!done) begin
         report_failure("reference model ran off without reaching HALT");
      end
   endtask

   task automatic sample_cycle();
      @(negedge clk);
      if (wb_en) begin
         got_reg.push_back(wb_reg);
         got_data.push_back(wb_data);
      end
   endtask

   task automatic run_and_check(input string test_name, input bit poke_busy);
      int cnt;
      run_model();
      got_reg.delete();
      got_data.delete();
      step();
      start = 1'b1;
      step();
      start = 1'b0;
      if (poke_busy) begin
         // Loader write while the CPU runs
         prog_we = 1'b1;
         prog_addr = mem_addr_t'(POKE_ADDR);
         prog_data = 16'h0000;
         step();
         prog_we = 1'b0;
      end
      cnt = 0;
      while (got_reg.size() < exp_reg.size() && cnt < TIMEOUT) begin
         sample_cycle();
         cnt++;
      end
      if (got_reg.size() < exp_reg.size()) begin
         report_failure({test_name, ": timed out waiting for writebacks"});
      end
      cnt = 0;
      while (busy && cnt < TIMEOUT) begin
         sample_cycle();
         cnt++;
      end
      if (busy) begin
         report_failure({test_name, ": busy never fell after HALT"});
      end
      // Anything retiring after HALT shows up here
      repeat (4) sample_cycle();
      if (got_reg.size() != exp_reg.size()) begin
         report_failure($sformatf("%s: saw %0d writebacks, expected %0d",
                                  test_name, got_reg.size(), exp_reg.size()));
      end
      for (int i = 0; i < exp_reg.size() && i < got_reg.size(); i++) begin
         check_reg({test_name, " wb_reg"}, got_reg[i], exp_reg[i]);
         check_word({test_name, " wb_data"}, got_data[i], exp_data[i]);
      end
      check_bit({test_name, " err"}, err, exp_err);
   endtask

   task automatic test_forwarding();
      reset_dut();
      prog = {enc_imm(OP_ADDI, 1, 0, 5), enc_imm(OP_ADDI, 2, 1, -3),
              enc_alu(OP_ADD, 3, 1, 2), enc_alu(OP_SUB, 4, 3, 1),
              enc_alu(OP_AND, 5, 4, 3), enc_alu(OP_XOR, 6, 5, 4),
              enc_alu(OP_ADD, 7, 6, 6), enc_imm(OP_HALT, 0, 0, 0)};
      load_program();
      run_and_check("forwarding", 1'b0);
   endtask

   // Stores and loads near address 60 clear of the program
   task automatic test_load_store();
      reset_dut();
      prog = {enc_imm(OP_ADDI, 1, 0, 30), enc_alu(OP_ADD, 1, 1, 1),
              enc_imm(OP_ADDI, 2, 0, -7), enc_imm(OP_ST, 2, 1, 4),
              enc_imm(OP_LD, 3, 1, 4), enc_alu(OP_ADD, 4, 3, 3),
              enc_imm(OP_LD, 5, 1, 0), enc_alu(OP_XOR, 6, 5, 4),
              enc_imm(OP_ST, 6, 1, 5), enc_imm(OP_LD, 7, 1, 5),
              enc_imm(OP_ST, 7, 1, 6), enc_imm(OP_LD, 2, 1, 6),
              enc_imm(OP_HALT, 0, 0, 0)};
      load_program();
      load_word(mem_addr_t'(60), 16'h1234);
      run_and_check("load_store", 1'b0);
   endtask

   task automatic test_halt();
      reset_dut();
      prog = {enc_imm(OP_ADDI, 1, 0, 9), enc_imm(OP_ADDI, 2, 1, 1),
              enc_imm(OP_HALT, 0, 0, 0), enc_imm(OP_ADDI, 3, 0, 7),
              enc_alu(OP_ADD, 4, 1, 2), enc_imm(OP_ADDI, 5, 0, 1),
              enc_imm(OP_HALT, 0, 0, 0)};
      load_program();
      run_and_check("halt", 1'b0);
      check_bit("halt busy", busy, 1'b0);
   endtask

   task automatic test_illegal();
      reset_dut();
      prog = {enc_imm(OP_ADDI, 1, 0, 12), 16'hF000, enc_alu(OP_ADD, 2, 1, 1),
              16'hA3C0, enc_alu(OP_SUB, 3, 2, 1), enc_imm(OP_HALT, 0, 0, 0)};
      load_program();
      run_and_check("illegal", 1'b0);
      reset_dut();
      check_bit("err after reset", err, 1'b0);
      check_bit("busy after reset", busy, 1'b0);
      check_bit("wb_en after reset", wb_en, 1'b0);
   endtask

   task automatic test_load_blocked();
      reset_dut();
      prog = {enc_imm(OP_ADDI, 1, 0, 25), enc_alu(OP_ADD, 1, 1, 1),
              enc_alu(OP_ADD, 1, 1, 1), enc_imm(OP_LD, 2, 1, 0),
              enc_imm(OP_ADDI, 3, 2, 1), enc_imm(OP_HALT, 0, 0, 0)};
      load_program();
      load_word(mem_addr_t'(POKE_ADDR), 16'hBEEF);
      run_and_check("load_blocked", 1'b1);
      // Same program again straight from memory
      reset_dut();
      run_and_check("load_blocked rerun", 1'b0);
   endtask

   task automatic test_random();
      opcode_t alu_ops [5];
      opcode_t op;
      alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI};
      reset_dut();
      prog.delete();
      for (int i = 0; i < 28; i++) begin
         op = alu_ops[$urandom % 5];
         if (op == OP_ADDI) begin
            prog.push_back(enc_imm(op, $urandom % 8, $urandom % 8, $urandom % 64));
         end else begin
            prog.push_back(enc_alu(op, $urandom % 8, $urandom % 8, $urandom % 8));
         end
      end
      prog.push_back(enc_imm(OP_HALT, 0, 0, 0));
      load_program();
      run_and_check("random", 1'b0);
   endtask

   initial begin
      rst = 1'b1;
      start = 1'b0;
      prog_we = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      value_errors = 0;
      other_errors = 0;
      void'($urandom(12));
      test_forwarding();
      test_load_store();
      test_halt();
      test_illegal();
      test_load_blocked();
      test_random();
      $display("Checks done: %0d value errors, %0d other failures",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- cpu_top.f
+incdir+.
cpu_pkg.sv
mem_arbiter.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
tb_cpu_top.sv
